// ==== rtl/core_fetch_pkg.sv ====
// Instruction fetch package
// Bus widths, the reset address and fetch buffer sizing shared by the
// fetch stage, the fetch buffer and the decode handoff stage
package core_fetch_pkg;

    // ----------------------------------------------------------------------
    // Core and bus widths
    // ----------------------------------------------------------------------

    localparam int XLEN       = 64;          // PC and redirect target width
    localparam int MEM_ADDR_W = 64;          // Memory request address
    localparam int MEM_DATA_W = 64;          // One 8-byte read word

    // Window handed to decode, one error tag per halfword
    localparam int FD_IBUF_W  = 32;          // Up to one 32-bit instruction
    localparam int FD_ERR_W   = 2;           // Tags for the two halfwords

    // ----------------------------------------------------------------------
    // Fetch buffer sizing
    // ----------------------------------------------------------------------

    localparam int BUF_BYTES   = 16;         // Two memory words of storage
    localparam int BUF_DEPTH_W = 5;          // Counts 0 to 16 bytes

    // ----------------------------------------------------------------------
    // Reset state
    // ----------------------------------------------------------------------

    // First fetch address and first PC, 8-byte aligned
    localparam logic [XLEN-1:0] PC_RESET_ADDRESS = 64'h1000_0000;

endpackage

// ==== rtl/core_pipe_fetch_buffer.sv ====
// Fetch buffer
// Byte shift buffer that realigns fetched words at halfword granularity.
// Fills append the top bytes of a memory word behind the valid bytes,
// drains remove 2 or 4 bytes from the front, each halfword carries an
// error tag
`timescale 1ns/1ps

module core_pipe_fetch_buffer
    import core_fetch_pkg::*;
(
    input  logic                   g_clk,
    input  logic                   g_resetn,
    input  logic                   flush,      // Drop everything
    input  logic                   fill_en,    // Load a word this cycle
    input  logic                   fill_2,     // Top 2 bytes of the word
    input  logic                   fill_4,     // Top 4 bytes
    input  logic                   fill_6,     // Top 6 bytes
    input  logic                   fill_8,     // Whole word
    input  logic [MEM_DATA_W-1:0]  data_in,
    input  logic                   error_in,   // Bus error for this word
    input  logic                   drain_2,    // Front 16-bit instr consumed
    input  logic                   drain_4,    // Front 32-bit instr consumed
    output logic [BUF_DEPTH_W-1:0] depth,      // Valid bytes now
    output logic [BUF_DEPTH_W-1:0] n_depth,    // Valid bytes next cycle
    output logic [FD_IBUF_W-1:0]   data_out,
    output logic [FD_ERR_W-1:0]    error_out
);

    localparam int BUF_W    = BUF_BYTES * 8;
    localparam int HW_N     = BUF_BYTES / 2;
    localparam int IN_BYTES = MEM_DATA_W / 8;

    // ----------------------------------------------------------------------
    // Storage
    // ----------------------------------------------------------------------

    logic [BUF_W-1:0]       data_q;          // Byte 0 is the front
    logic [HW_N-1:0]        err_q;           // Bit n tags halfword n
    logic [BUF_DEPTH_W-1:0] depth_q;

    logic [BUF_DEPTH_W-1:0] drain_bytes;
    logic [BUF_DEPTH_W-1:0] fill_bytes;
    logic [BUF_DEPTH_W-1:0] fill_skip;       // Low bytes of the word not loaded
    logic [BUF_DEPTH_W-1:0] kept;            // Bytes left after the drain

    logic [MEM_DATA_W-1:0]  in_aligned;      // Loaded bytes moved to byte 0
    logic [BUF_W-1:0]       old_sh;
    logic [BUF_W-1:0]       ins_data;
    logic [BUF_W-1:0]       ins_mask;
    logic [BUF_W-1:0]       n_data;
    logic [HW_N-1:0]        old_err_sh;
    logic [HW_N-1:0]        ins_emask;
    logic [HW_N-1:0]        n_err;

    // ----------------------------------------------------------------------
    // Byte counts
    // ----------------------------------------------------------------------

    always_comb begin
        drain_bytes = '0;
        if (drain_4) begin
            drain_bytes = BUF_DEPTH_W'(4);
        end else if (drain_2) begin
            drain_bytes = BUF_DEPTH_W'(2);
        end
    end

    always_comb begin
        fill_bytes = '0;
        if (fill_en) begin
            if (fill_8) begin
                fill_bytes = BUF_DEPTH_W'(8);
            end else if (fill_6) begin
                fill_bytes = BUF_DEPTH_W'(6);
            end else if (fill_4) begin
                fill_bytes = BUF_DEPTH_W'(4);
            end else if (fill_2) begin
                fill_bytes = BUF_DEPTH_W'(2);
            end
        end
    end

    assign kept      = depth_q - drain_bytes;
    assign fill_skip = BUF_DEPTH_W'(IN_BYTES) - fill_bytes;
    assign n_depth   = flush ? '0 : kept + fill_bytes;

    // ----------------------------------------------------------------------
    // Realignment
    // ----------------------------------------------------------------------

    assign in_aligned = data_in >> {fill_skip, 3'b000};   // Zero above the loaded bytes
    assign old_sh     = data_q >> {drain_bytes, 3'b000};

    // New bytes land right behind the kept ones
    assign ins_data = {{(BUF_W-MEM_DATA_W){1'b0}}, in_aligned} << {kept, 3'b000};
    assign ins_mask = {{(BUF_W-MEM_DATA_W){1'b0}},
                       ~({MEM_DATA_W{1'b1}} << {fill_bytes, 3'b000})} << {kept, 3'b000};
    assign n_data   = (old_sh & ~ins_mask) | ins_data;

    // Same merge at halfword granularity for the tags
    assign old_err_sh = err_q >> drain_bytes[BUF_DEPTH_W-1:1];
    assign ins_emask  = ~({HW_N{1'b1}} << fill_bytes[BUF_DEPTH_W-1:1])
                        << kept[BUF_DEPTH_W-1:1];
    assign n_err      = (old_err_sh & ~ins_emask) | ({HW_N{error_in}} & ins_emask);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            depth_q <= '0;
        end else begin
            depth_q <= n_depth;                  // Flush wins over fill
        end
    end

    always_ff @(posedge g_clk) begin
        data_q <= n_data;
        err_q  <= n_err;
    end

    assign depth     = depth_q;
    assign data_out  = data_q[FD_IBUF_W-1:0];
    assign error_out = err_q[FD_ERR_W-1:0];

endmodule

// ==== rtl/core_pipe_fetch.sv ====
// Fetch stage
// Issues aligned 8-byte requests to instruction memory, tracks responses
// in flight, drops stale responses after a redirect and feeds the fetch
// buffer with the right byte mask
`timescale 1ns/1ps

module core_pipe_fetch
    import core_fetch_pkg::*;
(
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  cf_valid,      // Redirect request
    output logic                  cf_ack,        // Redirect taken
    input  logic [XLEN-1:0]       cf_target,     // Halfword aligned target
    output logic                  imem_req,
    output logic [MEM_ADDR_W-1:0] imem_addr,     // Always 8-byte aligned
    input  logic                  imem_gnt,
    input  logic                  imem_err,      // Valid one cycle after gnt
    input  logic [MEM_DATA_W-1:0] imem_rdata,    // Valid one cycle after gnt
    output logic                  s1_i16bit,     // 16-bit instr at the front
    output logic                  s1_i32bit,     // 32-bit instr at the front
    output logic [FD_IBUF_W-1:0]  s1_instr,
    output logic [FD_ERR_W-1:0]   s1_ferr,
    input  logic                  s1_eat_2,
    input  logic                  s1_eat_4
);

    localparam int WORD_BYTES = MEM_DATA_W / 8;

    // ----------------------------------------------------------------------
    // Events
    // ----------------------------------------------------------------------

    logic e_cf_change;                           // Redirect handshake
    logic e_imem_req;                            // Request granted
    logic imem_recv;                             // Response on the bus

    assign cf_ack      = !imem_req || imem_gnt;  // No request left hanging
    assign e_cf_change = cf_valid && cf_ack;
    assign e_imem_req  = imem_req && imem_gnt;

    // ----------------------------------------------------------------------
    // Buffer side signals
    // ----------------------------------------------------------------------

    logic [BUF_DEPTH_W-1:0] buf_depth;
    logic [BUF_DEPTH_W-1:0] n_buf_depth;
    logic [FD_IBUF_W-1:0]   buf_data_out;
    logic [FD_ERR_W-1:0]    buf_error_out;
    logic                   buf_fill_en;
    logic                   buf_fill_8;
    logic                   buf_drain_2;
    logic                   buf_drain_4;
    logic                   buf_ready;       // Room for one more word

    logic                   part_2;          // Next fill takes top 2 bytes
    logic                   part_4;
    logic                   part_6;

    // ----------------------------------------------------------------------
    // Request issue and address tracking
    // ----------------------------------------------------------------------

    // Next depth already counts any word landing now, and a granted
    // request holds issue back until its word is counted
    assign buf_ready = (n_buf_depth <= BUF_DEPTH_W'(BUF_BYTES - WORD_BYTES)) && !e_imem_req;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            imem_req  <= 1'b0;
            imem_recv <= 1'b0;
            imem_addr <= MEM_ADDR_W'(PC_RESET_ADDRESS);
        end else begin
            imem_req  <= (imem_req && !imem_gnt) || buf_ready;
            imem_recv <= e_imem_req;             // Response follows the grant
            if (e_cf_change) begin
                imem_addr <= {cf_target[MEM_ADDR_W-1:3], 3'b000};
            end else if (e_imem_req) begin
                imem_addr <= imem_addr + MEM_ADDR_W'(WORD_BYTES);
            end
        end
    end

    // ----------------------------------------------------------------------
    // Outstanding responses and discard
    // ----------------------------------------------------------------------

    logic [1:0] reqs_outstanding;                // Granted, not yet returned
    logic [1:0] n_reqs_outstanding;
    logic [1:0] rsps_ignore;                     // Stale responses to drop
    logic       ignore_rsp;

    assign n_reqs_outstanding = reqs_outstanding + {1'b0, e_imem_req} - {1'b0, imem_recv};
    assign ignore_rsp         = |rsps_ignore;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            reqs_outstanding <= 2'd0;
            rsps_ignore      <= 2'd0;
        end else begin
            reqs_outstanding <= n_reqs_outstanding;
            if (e_cf_change) begin
                rsps_ignore <= n_reqs_outstanding;   // All still in flight are stale
            end else if (imem_recv && ignore_rsp) begin
                rsps_ignore <= rsps_ignore - 2'd1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Fill control
    // ----------------------------------------------------------------------

    assign buf_fill_en = imem_recv && !ignore_rsp;

    // Partial masks apply to the first useful word after a redirect
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            part_2 <= 1'b0;
            part_4 <= 1'b0;
            part_6 <= 1'b0;
        end else if (e_cf_change) begin
            part_2 <= cf_target[2:0] == 3'd6;
            part_4 <= cf_target[2:0] == 3'd4;
            part_6 <= cf_target[2:0] == 3'd2;
        end else if (buf_fill_en) begin
            part_2 <= 1'b0;
            part_4 <= 1'b0;
            part_6 <= 1'b0;
        end
    end

    assign buf_fill_8 = !(part_2 || part_4 || part_6);

    // ----------------------------------------------------------------------
    // Front of buffer classification
    // ----------------------------------------------------------------------

    assign s1_i16bit = buf_depth >= BUF_DEPTH_W'(2) && buf_data_out[1:0] != 2'b11;
    assign s1_i32bit = buf_depth >= BUF_DEPTH_W'(4) && buf_data_out[1:0] == 2'b11;
    assign s1_instr  = buf_data_out;
    assign s1_ferr   = buf_error_out;

    assign buf_drain_2 = s1_i16bit && s1_eat_2;
    assign buf_drain_4 = s1_i32bit && s1_eat_4;

    core_pipe_fetch_buffer u_fetch_buffer (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .flush     (e_cf_change),
        .fill_en   (buf_fill_en),
        .fill_2    (part_2),
        .fill_4    (part_4),
        .fill_6    (part_6),
        .fill_8    (buf_fill_8),
        .data_in   (imem_rdata),
        .error_in  (imem_err),
        .drain_2   (buf_drain_2),
        .drain_4   (buf_drain_4),
        .depth     (buf_depth),
        .n_depth   (n_buf_depth),
        .data_out  (buf_data_out),
        .error_out (buf_error_out)
    );

endmodule

// ==== rtl/core_pipe_decode_accept.sv ====
// Decode handoff stage
// Pairs each instruction from the fetch buffer with its PC and size,
// hands it on through valid/ready and tells fetch how much was consumed
`timescale 1ns/1ps

module core_pipe_decode_accept
    import core_fetch_pkg::*;
(
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  logic                 cf_valid,
    input  logic                 cf_ack,
    input  logic [XLEN-1:0]      cf_target,
    input  logic                 s1_i16bit,
    input  logic                 s1_i32bit,
    input  logic [FD_IBUF_W-1:0] s1_instr,
    input  logic [FD_ERR_W-1:0]  s1_ferr,
    output logic                 s1_eat_2,     // Consumed a 16-bit instr
    output logic                 s1_eat_4,     // Consumed a 32-bit instr
    output logic                 out_valid,
    input  logic                 out_ready,
    output logic [XLEN-1:0]      out_pc,
    output logic [FD_IBUF_W-1:0] out_instr,
    output logic                 out_i32,      // 32-bit encoding
    output logic [FD_ERR_W-1:0]  out_err       // Per halfword fetch error
);

    logic [XLEN-1:0] pc_q;
    logic            e_cf_change;
    logic            e_xfer;                   // Instruction handed on

    // ----------------------------------------------------------------------
    // Handshake
    // ----------------------------------------------------------------------

    assign e_cf_change = cf_valid && cf_ack;

    // Front of the buffer is stale once a redirect is pending
    assign out_valid = (s1_i16bit || s1_i32bit) && !cf_valid;
    assign e_xfer    = out_valid && out_ready;

    assign s1_eat_2 = e_xfer && !s1_i32bit;
    assign s1_eat_4 = e_xfer && s1_i32bit;

    // ----------------------------------------------------------------------
    // Program counter
    // ----------------------------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc_q <= PC_RESET_ADDRESS;
        end else if (e_cf_change) begin
            pc_q <= cf_target;
        end else if (e_xfer) begin
            pc_q <= pc_q + (s1_i32bit ? XLEN'(4) : XLEN'(2));
        end
    end

    // ----------------------------------------------------------------------
    // Output payload
    // ----------------------------------------------------------------------

    assign out_pc    = pc_q;
    assign out_i32   = s1_i32bit;
    assign out_instr = s1_i32bit ? s1_instr
                                 : {{(FD_IBUF_W-16){1'b0}}, s1_instr[15:0]};
    // Second halfword does not belong to a 16-bit instr
    assign out_err   = s1_i32bit ? s1_ferr
                                 : {{(FD_ERR_W-1){1'b0}}, s1_ferr[0]};

endmodule

// ==== rtl/core_fetch_top.sv ====
// Instruction fetch top level
// Joins the fetch stage and the decode handoff stage
`timescale 1ns/1ps

module core_fetch_top
    import core_fetch_pkg::*;
(
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  cf_valid,
    output logic                  cf_ack,
    input  logic [XLEN-1:0]       cf_target,
    output logic                  imem_req,
    output logic [MEM_ADDR_W-1:0] imem_addr,
    input  logic                  imem_gnt,
    input  logic                  imem_err,
    input  logic [MEM_DATA_W-1:0] imem_rdata,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [XLEN-1:0]       out_pc,
    output logic [FD_IBUF_W-1:0]  out_instr,
    output logic                  out_i32,
    output logic [FD_ERR_W-1:0]   out_err
);

    // ----------------------------------------------------------------------
    // Fetch to handoff
    // ----------------------------------------------------------------------

    logic                 s1_i16bit;
    logic                 s1_i32bit;
    logic [FD_IBUF_W-1:0] s1_instr;
    logic [FD_ERR_W-1:0]  s1_ferr;
    logic                 s1_eat_2;
    logic                 s1_eat_4;

    core_pipe_fetch u_fetch (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .cf_valid   (cf_valid),
        .cf_ack     (cf_ack),
        .cf_target  (cf_target),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_gnt   (imem_gnt),
        .imem_err   (imem_err),
        .imem_rdata (imem_rdata),
        .s1_i16bit  (s1_i16bit),
        .s1_i32bit  (s1_i32bit),
        .s1_instr   (s1_instr),
        .s1_ferr    (s1_ferr),
        .s1_eat_2   (s1_eat_2),
        .s1_eat_4   (s1_eat_4)
    );

    core_pipe_decode_accept u_decode_accept (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .cf_valid  (cf_valid),
        .cf_ack    (cf_ack),
        .cf_target (cf_target),
        .s1_i16bit (s1_i16bit),
        .s1_i32bit (s1_i32bit),
        .s1_instr  (s1_instr),
        .s1_ferr   (s1_ferr),
        .s1_eat_2  (s1_eat_2),
        .s1_eat_4  (s1_eat_4),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pc    (out_pc),
        .out_instr (out_instr),
        .out_i32   (out_i32),
        .out_err   (out_err)
    );

endmodule

// ==== tb/tb_imem_model.sv ====
// Instruction memory responder
// Grants after a random delay, answers one cycle after the grant from a
// seeded 64-word image and flags a bus error over one address range
`timescale 1ns/1ps

module tb_imem_model
    import core_fetch_pkg::*;
#(
    parameter logic [31:0]           SEED   = 32'h1,
    parameter logic [MEM_ADDR_W-1:0] ERR_LO = '0,    // First erroring word
    parameter logic [MEM_ADDR_W-1:0] ERR_HI = '0     // End of range, exclusive
) (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  imem_req,
    input  logic [MEM_ADDR_W-1:0] imem_addr,
    output logic                  imem_gnt,
    output logic                  imem_err,
    output logic [MEM_DATA_W-1:0] imem_rdata
);

    logic [MEM_DATA_W-1:0] image [64];           // Wraps every 512 bytes
    logic [31:0]           rnd_state;
    logic                  granted_q;            // Grant taken at last rising edge
    logic [MEM_ADDR_W-1:0] gaddr_q;
    logic                  waiting;              // Delay drawn for this request
    logic [1:0]            delay;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ----------------------------------------------------------------------
    // Response
    // ----------------------------------------------------------------------

    always @(posedge g_clk) begin
        if (!g_resetn) begin
            granted_q <= 1'b0;
        end else begin
            granted_q <= imem_req && imem_gnt;
        end
        gaddr_q <= imem_addr;
    end

    initial begin
        rnd_state = SEED;
        for (int i = 0; i < 64; i++) begin
            rnd_state = xorshift32(rnd_state);
            image[i][63:32] = rnd_state;
            rnd_state = xorshift32(rnd_state);
            image[i][31:0] = rnd_state;
        end
        imem_gnt   = 1'b0;
        imem_err   = 1'b0;
        imem_rdata = '0;
        waiting    = 1'b0;
        delay      = 2'd0;
        forever begin
            @(negedge g_clk);
            rnd_state = xorshift32(rnd_state);
            if (granted_q) begin
                // Upper address bits folded in, each wrap of the image differs
                imem_rdata = image[gaddr_q[8:3]] ^ (gaddr_q >> 9);
                imem_err   = gaddr_q >= ERR_LO && gaddr_q < ERR_HI;
                waiting    = 1'b0;
            end else begin
                imem_rdata = {rnd_state, ~rnd_state};   // Junk between responses
                imem_err   = 1'b0;
            end
            if (imem_req) begin
                if (!waiting) begin
                    delay   = rnd_state[5:4];            // 0 to 3 cycles
                    waiting = 1'b1;
                end else if (delay != 2'd0) begin
                    delay = delay - 2'd1;
                end
                imem_gnt = delay == 2'd0;
            end else begin
                imem_gnt = 1'b0;
            end
        end
    end

endmodule

// ==== tb/tb_core_fetch.sv ====
// Instruction fetch testbench
// Random redirects, back-pressure and grant delays, checked against a
// walk of the program image and against the bus and hold rules
`timescale 1ns/1ps

module tb_core_fetch
    import core_fetch_pkg::*;
();

    localparam logic [31:0]     SEED         = 32'h4f58_6f44;
    localparam int              RESET_CYCLES = 16;
    localparam int              N_CHECKS     = 2000;
    localparam int              RUN_LIMIT    = 60000;    // Cycles for the whole run
    localparam int              STALL_LIMIT  = 400;      // Cycles with no transfer
    localparam int              ACK_LIMIT    = 40;       // Cycles for cf_ack
    localparam logic [XLEN-1:0] ERR_LO       = PC_RESET_ADDRESS + 64'h80;
    localparam logic [XLEN-1:0] ERR_HI       = PC_RESET_ADDRESS + 64'hc0;

    logic                  g_clk;
    logic                  g_resetn;
    logic                  cf_valid;
    logic                  cf_ack;
    logic [XLEN-1:0]       cf_target;
    logic                  imem_req;
    logic [MEM_ADDR_W-1:0] imem_addr;
    logic                  imem_gnt;
    logic                  imem_err;
    logic [MEM_DATA_W-1:0] imem_rdata;
    logic                  out_valid;
    logic                  out_ready;
    logic [XLEN-1:0]       out_pc;
    logic [FD_IBUF_W-1:0]  out_instr;
    logic                  out_i32;
    logic [FD_ERR_W-1:0]   out_err;

    logic [31:0]           rnd_state;
    int                    ack_wait;
    logic [XLEN-1:0]       exp_pc;               // Model PC
    int                    n_checked;
    int                    n_redirects;
    int                    idle_cycles;
    logic                  cf_taken;             // Redirect accepted at last edge
    logic                  hold_q;               // Output stalled last cycle
    logic [XLEN-1:0]       held_pc;
    logic [FD_IBUF_W-1:0]  held_instr;
    logic                  held_i32;
    logic [FD_ERR_W-1:0]   held_err;
    logic                  req_wait_q;           // Request waited for grant
    logic [MEM_ADDR_W-1:0] req_addr_q;

    core_fetch_top DUT (.*);

    tb_imem_model #(.SEED(SEED), .ERR_LO(ERR_LO), .ERR_HI(ERR_HI)) u_imem (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_gnt   (imem_gnt),
        .imem_err   (imem_err),
        .imem_rdata (imem_rdata)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Image word with the upper address bits folded in, as memory returns it
    function automatic logic [15:0] halfword_at(input logic [XLEN-1:0] addr);
        logic [63:0] word;
        word = u_imem.image[addr[8:3]] ^ (addr >> 9);
        word = word >> {addr[2:1], 4'b0000};
        return word[15:0];
    endfunction

    function automatic logic err_at(input logic [XLEN-1:0] addr);
        return {addr[XLEN-1:3], 3'b000} >= ERR_LO && {addr[XLEN-1:3], 3'b000} < ERR_HI;
    endfunction

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (exp == act) else begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            report_failure($sformatf("%s does not match the model", name));
        end
    endtask

    // ----------------------------------------------------------------------
    // Stimulus, falling edge
    // ----------------------------------------------------------------------

    task automatic drive_inputs();
        rnd_state = xorshift32(rnd_state);
        out_ready = (n_checked < 300) || (rnd_state[1:0] != 2'b00);   // Full speed first
        if (cf_valid) begin
            if (cf_taken) begin
                cf_valid = 1'b0;
                ack_wait = 0;
            end else begin
                ack_wait++;
                assert (ack_wait < ACK_LIMIT)
                    else report_failure("cf_ack never came for a pending redirect");
            end
        end else if (n_checked >= 600 && rnd_state[13:8] == 6'd0) begin
            cf_valid  = 1'b1;
            cf_target = PC_RESET_ADDRESS + {55'd0, rnd_state[24:17], 1'b0};   // 2-aligned
        end
    endtask

    initial begin
        g_clk = 1'b0;
        forever #4 g_clk = ~g_clk;                // 8 ns period
    end

    initial begin
        int cycles;
        rnd_state = SEED;
        ack_wait  = 0;
        g_resetn  = 1'b0;
        cf_valid  = 1'b0;
        cf_target = PC_RESET_ADDRESS;
        out_ready = 1'b1;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge g_clk);
            if (i > 0) begin
                assert (!imem_req && !out_valid)
                    else report_failure("imem_req or out_valid high during reset");
            end
        end
        @(negedge g_clk);
        g_resetn = 1'b1;
        @(posedge g_clk);
        @(posedge g_clk);
        assert (imem_req) else report_failure("imem_req did not rise after reset release");
        cycles = 0;
        while (n_checked < N_CHECKS && cycles < RUN_LIMIT) begin
            @(negedge g_clk);
            drive_inputs();
            cycles++;
        end
        if (n_checked >= N_CHECKS) begin
            $display("%0d instructions checked, %0d redirects", n_checked, n_redirects);
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            report_failure("run timed out before all instructions were checked");
        end
    end

    // ----------------------------------------------------------------------
    // Checks and reference walk, rising edge
    // ----------------------------------------------------------------------

    always @(posedge g_clk) begin
        logic [15:0]          hw0;
        logic                 is32;
        logic [FD_IBUF_W-1:0] exp_instr;
        logic [FD_ERR_W-1:0]  exp_err;
        if (!g_resetn) begin
            exp_pc      = PC_RESET_ADDRESS;
            n_checked   = 0;
            n_redirects = 0;
            idle_cycles = 0;
            cf_taken    = 1'b0;
            hold_q      = 1'b0;
            req_wait_q  = 1'b0;
        end else begin
            if (imem_req) begin
                assert (imem_addr[2:0] == 3'b000)
                    else report_failure("imem_addr not 8-byte aligned");
            end
            if (req_wait_q) begin
                assert (imem_req) else report_failure("imem_req dropped before imem_gnt");
                check_value("bus hold addr", req_addr_q, imem_addr);
            end
            // A request still waiting for its grant holds a redirect back
            if (imem_req && !imem_gnt) begin
                assert (!cf_ack) else report_failure("cf_ack high while a request waits");
            end else begin
                assert (cf_ack) else report_failure("cf_ack low with no request waiting");
            end
            if (cf_valid) begin
                assert (!out_valid)
                    else report_failure("out_valid high with a redirect pending");
            end else if (hold_q) begin
                assert (out_valid) else report_failure("out_valid dropped before out_ready");
                check_value("hold pc", held_pc, out_pc);
                check_value("hold instr", 64'(held_instr), 64'(out_instr));
                check_value("hold i32", 64'(held_i32), 64'(out_i32));
                check_value("hold err", 64'(held_err), 64'(out_err));
            end
            if (out_valid && out_ready) begin
                hw0  = halfword_at(exp_pc);
                is32 = hw0[1:0] == 2'b11;                // Length from low two bits
                if (is32) begin
                    exp_instr = {halfword_at(exp_pc + 64'd2), hw0};
                    exp_err   = {err_at(exp_pc + 64'd2), err_at(exp_pc)};
                end else begin
                    exp_instr = {16'h0000, hw0};
                    exp_err   = {1'b0, err_at(exp_pc)};
                end
                check_value("stream pc", exp_pc, out_pc);
                check_value("stream instr", 64'(exp_instr), 64'(out_instr));
                check_value("stream i32", 64'(is32), 64'(out_i32));
                check_value("stream err", 64'(exp_err), 64'(out_err));
                exp_pc      = exp_pc + (is32 ? 64'd4 : 64'd2);
                n_checked   = n_checked + 1;
                idle_cycles = 0;
            end else begin
                idle_cycles = idle_cycles + 1;
                assert (idle_cycles < STALL_LIMIT)
                    else report_failure("no instruction handed on");
            end
            if (cf_valid && cf_ack) begin
                exp_pc      = cf_target;                 // Model follows the redirect
                n_redirects = n_redirects + 1;
            end
            cf_taken   = cf_valid && cf_ack;
            hold_q     = out_valid && !out_ready;
            held_pc    = out_pc;
            held_instr = out_instr;
            held_i32   = out_i32;
            held_err   = out_err;
            req_wait_q = imem_req && !imem_gnt;
            req_addr_q = imem_addr;
        end
    end

endmodule

// ==== files.f ====
rtl/core_fetch_pkg.sv
rtl/core_pipe_fetch_buffer.sv
rtl/core_pipe_fetch.sv
rtl/core_pipe_decode_accept.sv
rtl/core_fetch_top.sv
tb/tb_imem_model.sv
tb/tb_core_fetch.sv

// ==== Makefile ====
# Verilator build and run of the instruction fetch testbench

VERILATOR ?= verilator
TOP       ?= tb_core_fetch
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
